/* Makefile */
SRCS := $(shell grep -v '^+' arp.f) verilog/arp_cfg.svh

obj_dir/Varp_tb: arp.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f arp.f --top-module arp_tb

.PHONY: run clean

run: obj_dir/Varp_tb
	@out="$$(./obj_dir/Varp_tb)"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

/* arp.f */
+incdir+verilog
verilog/arp_pkg.sv
verilog/crc32_d8.sv
verilog/arp_rx.sv
verilog/arp_tx.sv
verilog/arp.sv
test/arp_tb.sv

/* test/arp_golden.txt */
# board <board_mac> <board_ip> <des_ip>
# rx <refresh> <arp_tx_req> <dec_mac> <dec_ip>, tx <max_grant_delay> <arp_tx_req_after>
# every rx and tx record is followed by 42 hex bytes of Ethernet header and ARP payload
board 0a1b2c3d4e5f c0a80164 c0a80101
# request from A for the board
rx 1 1 001122334455 c0a8010a
ff ff ff ff ff ff 00 11 22 33 44 55 08 06 00 01 08 00 06 04 00
01 00 11 22 33 44 55 c0 a8 01 0a 00 00 00 00 00 00 c0 a8 01 64
# request from B for another host
rx 0 1 001122334455 c0a8010a
ff ff ff ff ff ff 00 aa bb cc dd ee 08 06 00 01 08 00 06 04 00
01 00 aa bb cc dd ee c0 a8 01 0b 00 00 00 00 00 00 c0 a8 01 99
# request from B with an IPv4 EtherType
rx 0 1 001122334455 c0a8010a
ff ff ff ff ff ff 00 aa bb cc dd ee 08 00 00 01 08 00 06 04 00
01 00 aa bb cc dd ee c0 a8 01 0b 00 00 00 00 00 00 c0 a8 01 64
# reply to A
tx 12 0
00 11 22 33 44 55 0a 1b 2c 3d 4e 5f 08 06 00 01 08 00 06 04 00
02 0a 1b 2c 3d 4e 5f c0 a8 01 64 00 11 22 33 44 55 c0 a8 01 0a
# reply from C to the board
rx 1 0 66778899aabb c0a80114
0a 1b 2c 3d 4e 5f 66 77 88 99 aa bb 08 06 00 01 08 00 06 04 00
02 66 77 88 99 aa bb c0 a8 01 14 0a 1b 2c 3d 4e 5f c0 a8 01 64
query
# broadcast request for des_ip
tx 12 0
ff ff ff ff ff ff 0a 1b 2c 3d 4e 5f 08 06 00 01 08 00 06 04 00
01 0a 1b 2c 3d 4e 5f c0 a8 01 64 00 00 00 00 00 00 c0 a8 01 01
# requests from A then C while the reply waits
rx 1 1 001122334455 c0a8010a
ff ff ff ff ff ff 00 11 22 33 44 55 08 06 00 01 08 00 06 04 00
01 00 11 22 33 44 55 c0 a8 01 0a 00 00 00 00 00 00 c0 a8 01 64
rx 1 1 66778899aabb c0a80114
ff ff ff ff ff ff 66 77 88 99 aa bb 08 06 00 01 08 00 06 04 00
01 66 77 88 99 aa bb c0 a8 01 14 00 00 00 00 00 00 c0 a8 01 64
query
# reply to the latest peer goes first
tx 16 1
66 77 88 99 aa bb 0a 1b 2c 3d 4e 5f 08 06 00 01 08 00 06 04 00
02 0a 1b 2c 3d 4e 5f c0 a8 01 64 66 77 88 99 aa bb c0 a8 01 14
tx 16 0
ff ff ff ff ff ff 0a 1b 2c 3d 4e 5f 08 06 00 01 08 00 06 04 00
01 0a 1b 2c 3d 4e 5f c0 a8 01 64 00 00 00 00 00 00 c0 a8 01 01
end

/* test/arp_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "arp_cfg.svh"

module arp_tb import arp_pkg::*; ();

    localparam int BODY_LEN   = 42;                // Ethernet header plus ARP payload
    localparam int FCS_POS    = `ARP_FRAME_LEN - 4;
    localparam int REFRESH_AT = 8 + BODY_LEN;      // First cycle after the last ARP byte

    logic        gmii_clk;
    logic        arst_n;
    gmii_byte_t  gmii_rx;
    gmii_byte_t  gmii_tx;
    logic [31:0] board_ip;
    logic [47:0] board_mac;
    logic [31:0] des_ip;
    logic        arp_query;
    logic        arp_tx_sel;
    logic        arp_tx_req;
    logic        arp_tx_done;
    logic        arp_working;
    logic [47:0] dec_mac;
    logic [31:0] dec_ip;
    logic        arp_refresh;

    int          peer_errs;
    int          byte_errs;
    int          bit_errs;
    int          other_errs;
    int          cycles;
    int          cycle_limit;
    integer      seed;
    logic [7:0]  frame [`ARP_FRAME_LEN];       // Full wire image of one frame

    arp i_dut (.*);

    always #5 gmii_clk = ~gmii_clk;

    always @(posedge gmii_clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            report_counts();
            $display("Test failed");
            $finish;
        end
    end

    task automatic report_counts();
        $display("Errors: peer %0d, byte %0d, bit %0d, other %0d",
                 peer_errs, byte_errs, bit_errs, other_errs);
    endtask

    task automatic check_peer(input arp_peer_t got, input arp_peer_t want);
        if (got !== want) begin
            peer_errs++;
            $display("Mismatch dec_mac/dec_ip at %0t: got %h/%h expected %h/%h",
                     $time, got.mac, got.ip, want.mac, want.ip);
        end
    endtask

    task automatic check_byte(input int idx, input gmii_byte_t got, input gmii_byte_t want);
        if (got !== want) begin
            byte_errs++;
            $display("Mismatch gmii_tx byte %0d at %0t: got %h expected %h",
                     idx, $time, got, want);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            bit_errs++;
            $display("Mismatch %0s at %0t: got %h expected %h", name, $time, got, want);
        end
    endtask

    // Ethernet FCS in MSB-first form, bytes fed LSB first
    function automatic logic [31:0] fcs_of(input int len);
        logic [31:0] crc;
        logic [31:0] rev;
        logic        fb;
        crc = 32'hFFFF_FFFF;
        for (int n = 8; n < len; n++) begin
            for (int b = 0; b < 8; b++) begin
                fb  = frame[n][b] ^ crc[31];
                crc = {crc[30:0], 1'b0} ^ (fb ? 32'h04C1_1DB7 : 32'h0);
            end
        end
        for (int b = 0; b < 32; b++) begin
            rev[b] = crc[31 - b];
        end
        return ~rev;  // Low byte goes out first
    endfunction

    // Preamble, SFD, body from file, zero pad, FCS
    task automatic read_frame(input integer fd);
        logic [7:0]  b;
        logic [31:0] fcs;
        integer      code;
        for (int i = 0; i < `ARP_PREAMBLE_LEN; i++) begin
            frame[i] = `ARP_PREAMBLE_BYTE;
        end
        frame[`ARP_PREAMBLE_LEN] = `ARP_SFD;
        for (int i = 0; i < BODY_LEN; i++) begin
            code = $fscanf(fd, "%h", b);
            if (code != 1) begin
                other_errs++;
                $display("Golden file ends inside a frame body");
            end
            frame[8 + i] = b;
        end
        for (int i = 8 + BODY_LEN; i < FCS_POS; i++) begin
            frame[i] = 8'h00;
        end
        fcs = fcs_of(FCS_POS);
        for (int i = 0; i < 4; i++) begin
            frame[FCS_POS + i] = fcs[8*i +: 8];
        end
    endtask

    task automatic run_rx(input integer fd);
        logic        want_refresh;
        logic        want_req;
        logic [47:0] mac;
        logic [31:0] ip;
        integer      code;
        code = $fscanf(fd, "%h %h %h %h", want_refresh, want_req, mac, ip);
        if (code != 4) begin
            other_errs++;
            $display("Golden rx record has an incomplete header line");
        end
        read_frame(fd);
        for (int i = 0; i < `ARP_FRAME_LEN + 4; i++) begin
            @(negedge gmii_clk);
            // Sampled before the next byte
            check_bit("arp_refresh", arp_refresh, want_refresh && (i == REFRESH_AT));
            if (i < `ARP_FRAME_LEN) begin
                gmii_rx = gmii_byte_t'{valid: 1'b1, data: frame[i]};
            end else begin
                gmii_rx = '0;
            end
        end
        check_peer(arp_peer_t'{mac: dec_mac, ip: dec_ip}, arp_peer_t'{mac: mac, ip: ip});
        check_bit("arp_tx_req", arp_tx_req, want_req);
    endtask

    task automatic run_tx(input integer fd);
        int          max_delay;
        int          delay;
        int          wait_cyc;
        int          dones;
        logic        want_req;
        gmii_byte_t  want;
        integer      code;
        code  = $fscanf(fd, "%d %h", max_delay, want_req);
        if (code != 2) begin
            other_errs++;
            $display("Golden tx record has an incomplete header line");
        end
        read_frame(fd);
        delay = $unsigned($random(seed)) % (max_delay + 1);
        for (int i = 0; i < delay; i++) begin
            @(negedge gmii_clk);
            check_bit("gmii_tx.valid", gmii_tx.valid, 1'b0);  // Held off by the grant
            check_bit("arp_tx_req", arp_tx_req, 1'b1);
        end
        @(negedge gmii_clk);
        check_bit("arp_tx_req", arp_tx_req, 1'b1);
        arp_tx_sel = 1'b1;
        @(negedge gmii_clk);
        arp_tx_sel = 1'b0;
        wait_cyc = 1;
        while (!gmii_tx.valid) begin
            @(negedge gmii_clk);
            wait_cyc++;
        end
        if (wait_cyc != 1) begin
            other_errs++;
            $display("gmii_tx valid rose %0d cycles after the grant, expected 1", wait_cyc);
        end
        dones = 0;
        for (int i = 0; i < `ARP_FRAME_LEN; i++) begin
            want = gmii_byte_t'{valid: 1'b1, data: frame[i]};
            check_byte(i, gmii_tx, want);
            check_bit("arp_working", arp_working, 1'b1);
            dones += arp_tx_done;
            @(negedge gmii_clk);
        end
        check_bit("gmii_tx.valid", gmii_tx.valid, 1'b0);
        check_bit("arp_tx_done", arp_tx_done, 1'b1);
        check_bit("arp_tx_req", arp_tx_req, want_req);  // Stays up if a frame still waits
        for (int i = 0; i < 3; i++) begin
            dones += arp_tx_done;
            check_bit("arp_working", arp_working, 1'b0);
            @(negedge gmii_clk);
        end
        if (dones != 1) begin
            other_errs++;
            $display("arp_tx_done pulsed %0d times for one frame", dones);
        end
    endtask

    task automatic run_query();
        @(negedge gmii_clk);
        arp_query = 1'b1;
        @(negedge gmii_clk);
        arp_query = 1'b0;
        check_bit("arp_tx_req", arp_tx_req, 1'b1);
    endtask

    initial begin
        integer        fd;
        integer        code;
        logic [127:0]  tag;
        logic [2047:0] rest;
        bit            finished;
        seed        = 17151;
        peer_errs   = 0;
        byte_errs   = 0;
        bit_errs    = 0;
        other_errs  = 0;
        cycles      = 0;
        cycle_limit = 200;
        gmii_clk    = 1'b0;
        arst_n      = 1'b0;
        gmii_rx     = '0;
        board_ip    = '0;
        board_mac   = '0;
        des_ip      = '0;
        arp_query   = 1'b0;
        arp_tx_sel  = 1'b0;
        repeat (8) @(posedge gmii_clk);
        @(negedge gmii_clk);
        arst_n = 1'b1;
        fd = $fopen("test/arp_golden.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("Cannot open test/arp_golden.txt");
        end else begin
            finished = 1'b0;
            while (!finished) begin
                code = $fscanf(fd, "%s", tag);
                if (code != 1) begin
                    other_errs++;
                    $display("Golden file ends without an end record");
                    finished = 1'b1;
                end else begin
                    if (tag != "#") begin
                        cycle_limit += 100;
                    end
                    case (tag)
                        "#":     code = $fgets(rest, fd);  // Skip comment line
                        "board": begin
                            code = $fscanf(fd, "%h %h %h", board_mac, board_ip, des_ip);
                            if (code != 3) begin
                                other_errs++;
                                $display("Golden board record is incomplete");
                            end
                        end
                        "rx":    run_rx(fd);
                        "tx":    run_tx(fd);
                        "query": run_query();
                        "end":   finished = 1'b1;
                        default: begin
                            other_errs++;
                            $display("Unknown record in golden file: %0s", tag);
                            finished = 1'b1;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        report_counts();
        if (peer_errs + byte_errs + bit_errs + other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/arp.sv */
`timescale 1ns/10ps
`default_nettype none

module arp import arp_pkg::*; (
    input  logic        gmii_clk,
    input  logic        arst_n,
    input  gmii_byte_t  gmii_rx,
    output gmii_byte_t  gmii_tx,
    input  logic [31:0] board_ip,
    input  logic [47:0] board_mac,
    input  logic [31:0] des_ip,
    input  logic        arp_query,
    input  logic        arp_tx_sel,
    output logic        arp_tx_req,
    output logic        arp_tx_done,
    output logic        arp_working,
    output logic [47:0] dec_mac,
    output logic [31:0] dec_ip,
    output logic        arp_refresh
);

    arp_peer_t   peer;
    logic        reply_pend_set;
    logic        crc_en;
    logic        crc_clr;
    logic [7:0]  crc_d8;
    logic [31:0] crc_next;

    assign dec_mac = peer.mac;
    assign dec_ip  = peer.ip;

    arp_rx i_arp_rx (
        .gmii_clk       (gmii_clk),
        .arst_n         (arst_n),
        .gmii_rx        (gmii_rx),
        .board_ip       (board_ip),
        .peer           (peer),
        .refresh        (arp_refresh),
        .reply_pend_set (reply_pend_set)
    );

    arp_tx i_arp_tx (
        .gmii_clk       (gmii_clk),
        .arst_n         (arst_n),
        .board_ip       (board_ip),
        .board_mac      (board_mac),
        .des_ip         (des_ip),
        .peer           (peer),
        .reply_pend_set (reply_pend_set),
        .arp_query      (arp_query),
        .arp_tx_sel     (arp_tx_sel),
        .crc_next       (crc_next),
        .crc_en         (crc_en),
        .crc_clr        (crc_clr),
        .crc_d8         (crc_d8),
        .gmii_tx        (gmii_tx),
        .arp_tx_req     (arp_tx_req),
        .arp_tx_done    (arp_tx_done),
        .arp_working    (arp_working)
    );

    // FCS bytes come from crc_next alone
    crc32_d8 i_crc32_d8 (
        .clk      (gmii_clk),
        .arst_n   (arst_n),
        .data     (crc_d8),
        .crc_en   (crc_en),
        .crc_clr  (crc_clr),
        .crc_data (),
        .crc_next (crc_next)
    );

endmodule

`default_nettype wire

/* verilog/arp_cfg.svh */
`ifndef ARP_CFG_SVH
`define ARP_CFG_SVH

// GMII framing
`define ARP_PREAMBLE_LEN  7
`define ARP_PREAMBLE_BYTE 8'h55
`define ARP_SFD           8'hD5

// Constant Ethernet and ARP header fields
`define ARP_ETHERTYPE     16'h0806
`define ARP_HTYPE         16'h0001
`define ARP_PTYPE         16'h0800
`define ARP_HLEN          8'd6
`define ARP_PLEN          8'd4

// 8 preamble/SFD + 14 header + 28 ARP + 18 pad + 4 FCS
`define ARP_FRAME_LEN     72

`endif

/* verilog/arp_pkg.sv */
`default_nettype none

package arp_pkg;

    // ARP operation field, low two bits
    typedef enum logic [1:0] {
        ARP_OP_REQUEST = 2'd1,
        ARP_OP_REPLY   = 2'd2
    } arp_op_e;

    // One end of an ARP exchange
    typedef struct packed {
        logic [47:0] mac;
        logic [31:0] ip;
    } arp_peer_t;

    // One GMII beat
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } gmii_byte_t;

endpackage

`default_nettype wire

/* verilog/arp_rx.sv */
`timescale 1ns/10ps
`default_nettype none
`include "arp_cfg.svh"

module arp_rx import arp_pkg::*; (
    input  logic        gmii_clk,
    input  logic        arst_n,
    input  gmii_byte_t  gmii_rx,
    input  logic [31:0] board_ip,
    output arp_peer_t   peer,
    output logic        refresh,
    output logic        reply_pend_set
);

    // Byte positions after the SFD
    localparam int ETH_TYPE_POS = 12;
    localparam int FIX_LAST     = 19;  // PLEN, last constant byte
    localparam int OP_HI_POS    = 20;
    localparam int OP_LO_POS    = 21;
    localparam int SHA_POS      = 22;
    localparam int SPA_POS      = 28;
    localparam int THA_POS      = 32;
    localparam int TPA_POS      = 38;
    localparam int LAST_POS     = 41;

    localparam logic [63:0] FIX_FIELDS = {`ARP_ETHERTYPE, `ARP_HTYPE, `ARP_PTYPE,
                                          `ARP_HLEN, `ARP_PLEN};

    typedef enum logic [1:0] {RX_IDLE, RX_PRE, RX_BODY, RX_DROP} rx_state_e;

    rx_state_e   st;
    logic [5:0]  cnt;       // Index of the byte being sampled
    logic        ok;        // Fixed fields matched so far
    arp_op_e     sh_op;
    logic [47:0] sh_mac;
    logic [31:0] sh_ip;
    logic [23:0] sh_tip;    // First three target IP bytes
    logic        is_pre;
    logic        is_sfd;
    logic        byte_bad;
    logic        hit;

    assign is_pre = (gmii_rx.data == `ARP_PREAMBLE_BYTE);
    assign is_sfd = (gmii_rx.data == `ARP_SFD);

    always_comb begin
        byte_bad = 1'b0;
        if (cnt >= ETH_TYPE_POS && cnt <= FIX_LAST) begin
            byte_bad = (gmii_rx.data != FIX_FIELDS[8*(FIX_LAST - cnt) +: 8]);
        end else if (cnt == OP_HI_POS) begin
            byte_bad = (gmii_rx.data != 8'd0);
        end else if (cnt == OP_LO_POS) begin
            byte_bad = (gmii_rx.data != 8'(ARP_OP_REQUEST)) &&
                       (gmii_rx.data != 8'(ARP_OP_REPLY));
        end
    end

    // Last byte completes the target IP compare
    assign hit = (st == RX_BODY) && gmii_rx.valid && (cnt == LAST_POS) && ok &&
                 ({sh_tip, gmii_rx.data} == board_ip);

    always_ff @(posedge gmii_clk or negedge arst_n) begin
        if (!arst_n) begin
            st  <= RX_IDLE;
            cnt <= '0;
            ok  <= 1'b0;
        end else if (!gmii_rx.valid) begin
            st <= RX_IDLE;  // Also aborts a short frame
        end else begin
            case (st)
                RX_IDLE: begin
                    st <= is_pre ? RX_PRE : RX_DROP;
                end
                RX_PRE: begin
                    if (is_sfd) begin
                        st  <= RX_BODY;
                        cnt <= '0;
                        ok  <= 1'b1;
                    end else if (!is_pre) begin
                        st <= RX_DROP;
                    end
                end
                RX_BODY: begin
                    cnt <= cnt + 6'd1;
                    if (byte_bad) begin
                        ok <= 1'b0;
                    end
                    if (cnt == LAST_POS) begin
                        st <= RX_DROP;  // Skip pad and FCS
                    end
                end
                default: begin
                    st <= RX_DROP;  // Wait for valid low
                end
            endcase
        end
    end

    // Shadow copies of the ARP fields
    always_ff @(posedge gmii_clk) begin
        if (st == RX_BODY && gmii_rx.valid) begin
            if (cnt == OP_LO_POS) begin
                sh_op <= arp_op_e'(gmii_rx.data[1:0]);
            end
            if (cnt >= SHA_POS && cnt < SPA_POS) begin
                sh_mac <= {sh_mac[39:0], gmii_rx.data};
            end
            if (cnt >= SPA_POS && cnt < THA_POS) begin
                sh_ip <= {sh_ip[23:0], gmii_rx.data};
            end
            if (cnt >= TPA_POS && cnt < LAST_POS) begin
                sh_tip <= {sh_tip[15:0], gmii_rx.data};
            end
        end
    end

    always_ff @(posedge gmii_clk or negedge arst_n) begin
        if (!arst_n) begin
            peer           <= '0;
            refresh        <= 1'b0;
            reply_pend_set <= 1'b0;
        end else begin
            refresh        <= hit;
            reply_pend_set <= hit && (sh_op == ARP_OP_REQUEST);
            if (hit) begin
                peer <= '{mac: sh_mac, ip: sh_ip};
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/arp_tx.sv */
`timescale 1ns/10ps
`default_nettype none
`include "arp_cfg.svh"

module arp_tx import arp_pkg::*; (
    input  logic        gmii_clk,
    input  logic        arst_n,
    input  logic [31:0] board_ip,
    input  logic [47:0] board_mac,
    input  logic [31:0] des_ip,
    input  arp_peer_t   peer,
    input  logic        reply_pend_set,
    input  logic        arp_query,
    input  logic        arp_tx_sel,
    input  logic [31:0] crc_next,
    output logic        crc_en,
    output logic        crc_clr,
    output logic [7:0]  crc_d8,
    output gmii_byte_t  gmii_tx,
    output logic        arp_tx_req,
    output logic        arp_tx_done,
    output logic        arp_working
);

    localparam int SFD_POS   = `ARP_PREAMBLE_LEN;
    localparam int HDR_START = SFD_POS + 1;
    localparam int BODY_LEN  = 42;                   // Ethernet header plus ARP payload
    localparam int PAD_START = HDR_START + BODY_LEN;
    localparam int FCS_START = `ARP_FRAME_LEN - 4;
    localparam int LAST      = `ARP_FRAME_LEN - 1;

    typedef enum logic [2:0] {ST_IDLE, ST_PRE, ST_BODY, ST_FCS, ST_DONE} tx_state_e;

    tx_state_e             st;
    logic [6:0]            cnt;         // Index of the byte on gmii_tx
    logic [6:0]            ld_idx;      // Index loaded at the next edge
    logic                  start;
    logic                  load;
    logic                  fin;
    logic                  reply_pend;
    logic                  query_pend;
    logic                  is_reply;
    arp_peer_t             tx_peer;     // Peer frozen at frame start
    logic                  tx_valid;
    logic [7:0]            tx_data;
    logic [7:0]            tx_byte;
    logic [47:0]           dst_mac;
    logic [47:0]           tgt_mac;
    logic [31:0]           tgt_ip;
    arp_op_e               tx_op;
    logic [8*BODY_LEN-1:0] body;

    assign arp_tx_req  = reply_pend | query_pend;
    assign start       = (st == ST_IDLE) && arp_tx_req && arp_tx_sel;
    assign fin         = (st == ST_FCS) && (cnt == LAST);
    assign load        = start || (st == ST_PRE) || (st == ST_BODY) || (st == ST_FCS && !fin);
    assign ld_idx      = (st == ST_IDLE) ? 7'd0 : cnt + 7'd1;
    assign arp_tx_done = (st == ST_DONE);
    assign arp_working = tx_valid;
    assign gmii_tx     = '{valid: tx_valid, data: tx_data};
    assign crc_d8      = tx_data;

    assign dst_mac = is_reply ? tx_peer.mac : 48'hFFFF_FFFF_FFFF;
    assign tgt_mac = is_reply ? tx_peer.mac : 48'h0;
    assign tgt_ip  = is_reply ? tx_peer.ip : des_ip;
    assign tx_op   = is_reply ? ARP_OP_REPLY : ARP_OP_REQUEST;

    assign body = {dst_mac, board_mac, `ARP_ETHERTYPE, `ARP_HTYPE, `ARP_PTYPE,
                   `ARP_HLEN, `ARP_PLEN, 14'd0, tx_op, board_mac, board_ip,
                   tgt_mac, tgt_ip};

    always_comb begin
        if (ld_idx < SFD_POS) begin
            tx_byte = `ARP_PREAMBLE_BYTE;
        end else if (ld_idx == SFD_POS) begin
            tx_byte = `ARP_SFD;
        end else if (ld_idx < PAD_START) begin
            tx_byte = body[8*(PAD_START - 1 - ld_idx) +: 8];
        end else if (ld_idx < FCS_START) begin
            tx_byte = 8'h00;  // Pad to minimum length
        end else begin
            tx_byte = ~crc_next[8*(ld_idx - FCS_START) +: 8];  // Low byte first
        end
    end

    always_ff @(posedge gmii_clk or negedge arst_n) begin
        if (!arst_n) begin
            st       <= ST_IDLE;
            cnt      <= '0;
            tx_valid <= 1'b0;
            crc_en   <= 1'b0;
            crc_clr  <= 1'b0;
            is_reply <= 1'b0;
        end else if (load) begin
            cnt      <= ld_idx;
            tx_valid <= 1'b1;
            crc_en   <= (ld_idx >= HDR_START) && (ld_idx < FCS_START);
            crc_clr  <= (ld_idx < HDR_START);
            if (ld_idx < HDR_START) begin
                st <= ST_PRE;
            end else if (ld_idx < FCS_START) begin
                st <= ST_BODY;
            end else begin
                st <= ST_FCS;
            end
            if (start) begin
                is_reply <= reply_pend;  // Reply takes priority
            end
        end else begin
            tx_valid <= 1'b0;
            crc_en   <= 1'b0;
            crc_clr  <= 1'b0;
            st       <= (st == ST_FCS) ? ST_DONE : ST_IDLE;
        end
    end

    always_ff @(posedge gmii_clk) begin
        if (start) begin
            tx_peer <= peer;
        end
        if (load) begin
            tx_data <= tx_byte;
        end
    end

    // A new set wins over the clear at frame end
    always_ff @(posedge gmii_clk or negedge arst_n) begin
        if (!arst_n) begin
            reply_pend <= 1'b0;
            query_pend <= 1'b0;
        end else begin
            if (reply_pend_set) begin
                reply_pend <= 1'b1;
            end else if (fin && is_reply) begin
                reply_pend <= 1'b0;
            end
            if (arp_query) begin
                query_pend <= 1'b1;
            end else if (fin && !is_reply) begin
                query_pend <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/crc32_d8.sv */
`timescale 1ns/10ps
`default_nettype none

module crc32_d8 (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [7:0]  data,
    input  logic        crc_en,
    input  logic        crc_clr,
    output logic [31:0] crc_data,
    output logic [31:0] crc_next
);

    localparam logic [31:0] POLY = 32'hEDB8_8320;  // Reflected 802.3 polynomial

    // Eight LSB-first shift steps over one byte
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] c;
        c = crc ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // Holds the remainder when not enabled
    assign crc_next = crc_en ? crc_byte(crc_data, data) : crc_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            crc_data <= '1;
        end else if (crc_clr) begin
            crc_data <= '1;  // All-ones preset
        end else if (crc_en) begin
            crc_data <= crc_next;
        end
    end

endmodule

`default_nettype wire
